// ==== Makefile ====
TOP := tb_ext_harness

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timescale 1ns/1ps -Wno-fatal -f sources.f --top-module $(TOP) -o sim

# pass only when the pass line appears in the output
run: compile
	out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir

// ==== logic/ext_harness_top.sv ====
// external device harness top level
// register demux, gpio counter, power switches and the slow memory path
`timescale 1ns/1ps

module ext_harness_top #(
  parameter logic [ext_pkg::DATA_W-1:0] CNT_MAX_RESET = ext_pkg::CNT_MAX_DEFAULT,
  parameter int unsigned NUM_DOMAINS        = ext_pkg::NUM_DOMAINS,
  parameter int unsigned SWITCH_ACK_LATENCY = ext_pkg::SWITCH_ACK_LATENCY,
  parameter int unsigned MEM_WORDS          = ext_pkg::MEM_WORDS,
  parameter int unsigned FIFO_DEPTH         = ext_pkg::FIFO_DEPTH,
  parameter int unsigned MEM_LATENCY        = ext_pkg::MEM_LATENCY
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       reg_valid_i,
  input  logic                       reg_write_i,
  input  logic [ext_pkg::ADDR_W-1:0] reg_addr_i,
  input  logic [ext_pkg::DATA_W-1:0] reg_wdata_i,
  output logic                       reg_ready_o,
  output logic [ext_pkg::DATA_W-1:0] reg_rdata_o,
  output logic                       reg_error_o,
  input  logic                       mem_req_i,
  input  logic                       mem_we_i,
  input  logic [3:0]                 mem_be_i,
  input  logic [ext_pkg::ADDR_W-1:0] mem_addr_i,
  input  logic [ext_pkg::DATA_W-1:0] mem_wdata_i,
  output logic                       mem_gnt_o,
  output logic                       mem_rvalid_o,
  output logic [ext_pkg::DATA_W-1:0] mem_rdata_o,
  input  logic                       gpio_i,
  output logic                       gpio_o,
  output logic                       intr_o,
  output logic [NUM_DOMAINS-1:0]     switch_n_o,
  output logic [NUM_DOMAINS-1:0]     iso_n_o
);

  // peripheral strobe side
  logic                       gpio_req;
  logic                       psw_req;
  logic                       periph_write;
  logic [1:0]                 periph_ofs;
  logic [ext_pkg::DATA_W-1:0] periph_wdata;
  logic [ext_pkg::DATA_W-1:0] gpio_rdata;
  logic [ext_pkg::DATA_W-1:0] psw_rdata;

  // FIFO head to memory
  logic                       fifo_valid;
  logic                       fifo_we;
  logic [3:0]                 fifo_be;
  logic [ext_pkg::ADDR_W-1:0] fifo_addr;
  logic [ext_pkg::DATA_W-1:0] fifo_wdata;
  logic                       fifo_pop;

  reg_periph_demux i_reg_periph_demux (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .reg_valid_i    (reg_valid_i),
    .reg_write_i    (reg_write_i),
    .reg_addr_i     (reg_addr_i),
    .reg_wdata_i    (reg_wdata_i),
    .gpio_rdata_i   (gpio_rdata),
    .psw_rdata_i    (psw_rdata),
    .reg_ready_o    (reg_ready_o),
    .reg_rdata_o    (reg_rdata_o),
    .reg_error_o    (reg_error_o),
    .gpio_req_o     (gpio_req),
    .psw_req_o      (psw_req),
    .periph_write_o (periph_write),
    .periph_ofs_o   (periph_ofs),
    .periph_wdata_o (periph_wdata)
  );

  gpio_cnt #(
    .CNT_MAX_RESET (CNT_MAX_RESET)
  ) i_gpio_cnt (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (gpio_req),
    .write_i (periph_write),
    .ofs_i   (periph_ofs),
    .wdata_i (periph_wdata),
    .gpio_i  (gpio_i),
    .rdata_o (gpio_rdata),
    .gpio_o  (gpio_o),
    .intr_o  (intr_o)
  );

  power_switch_ctrl #(
    .NUM_DOMAINS        (NUM_DOMAINS),
    .SWITCH_ACK_LATENCY (SWITCH_ACK_LATENCY)
  ) i_power_switch_ctrl (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (psw_req),
    .write_i    (periph_write),
    .ofs_i      (periph_ofs),
    .wdata_i    (periph_wdata),
    .rdata_o    (psw_rdata),
    .switch_n_o (switch_n_o),
    .iso_n_o    (iso_n_o)
  );

  mem_req_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) i_mem_req_fifo (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .mem_req_i    (mem_req_i),
    .mem_we_i     (mem_we_i),
    .mem_be_i     (mem_be_i),
    .mem_addr_i   (mem_addr_i),
    .mem_wdata_i  (mem_wdata_i),
    .pop_i        (fifo_pop),
    .mem_gnt_o    (mem_gnt_o),
    .fifo_valid_o (fifo_valid),
    .fifo_we_o    (fifo_we),
    .fifo_be_o    (fifo_be),
    .fifo_addr_o  (fifo_addr),
    .fifo_wdata_o (fifo_wdata)
  );

  slow_mem #(
    .NUM_WORDS (MEM_WORDS),
    .LATENCY   (MEM_LATENCY)
  ) i_slow_mem (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .fifo_valid_i (fifo_valid),
    .fifo_we_i    (fifo_we),
    .fifo_be_i    (fifo_be),
    .fifo_addr_i  (fifo_addr),
    .fifo_wdata_i (fifo_wdata),
    .pop_o        (fifo_pop),
    .mem_rvalid_o (mem_rvalid_o),
    .mem_rdata_o  (mem_rdata_o)
  );

endmodule

// ==== logic/ext_pkg.sv ====
// address map, register offsets and default parameter values
// for the external device harness

package ext_pkg;

  // bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // 4-bit peripheral index at this bit, so a 4 KiB window each
  localparam int unsigned PERIPH_SEL_LSB = 12;

  localparam logic [3:0] GPIO_CNT_IDX = 4'd0;
  localparam logic [3:0] POWER_SW_IDX = 4'd1;

  // word offset inside a peripheral window
  localparam int unsigned REG_OFS_LSB = 2;

  // gpio_cnt registers
  localparam logic [1:0] GPIO_REG_CNT_MAX = 2'd0;
  localparam logic [1:0] GPIO_REG_COUNT   = 2'd1;
  localparam logic [1:0] GPIO_REG_STATUS  = 2'd2;

  // power_switch_ctrl registers
  localparam logic [1:0] PSW_REG_SWITCH_OFF = 2'd0;
  localparam logic [1:0] PSW_REG_ACK        = 2'd1;

  // top-level parameter defaults
  localparam int unsigned CNT_MAX_DEFAULT    = 2048;
  localparam int unsigned SWITCH_ACK_LATENCY = 15;
  localparam int unsigned NUM_DOMAINS        = 2;
  localparam int unsigned MEM_WORDS          = 8192;
  localparam int unsigned FIFO_DEPTH         = 4;
  localparam int unsigned MEM_LATENCY        = 3;

endpackage

// ==== logic/gpio_cnt.sv ====
// gpio rising-edge counter with max, count and status registers
// toggles gpio_o and raises an interrupt when the max is reached
`timescale 1ns/1ps

module gpio_cnt #(
  parameter logic [ext_pkg::DATA_W-1:0] CNT_MAX_RESET = ext_pkg::CNT_MAX_DEFAULT
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       req_i,
  input  logic                       write_i,
  input  logic [1:0]                 ofs_i,
  input  logic [ext_pkg::DATA_W-1:0] wdata_i,
  input  logic                       gpio_i,
  output logic [ext_pkg::DATA_W-1:0] rdata_o,
  output logic                       gpio_o,
  output logic                       intr_o
);

  logic                       sync1_q;
  logic                       sync2_q;
  logic                       prev_q;
  logic                       rise;
  logic [ext_pkg::DATA_W-1:0] cnt_max_q;
  logic [ext_pkg::DATA_W-1:0] count_q;
  logic [ext_pkg::DATA_W-1:0] count_inc;
  logic                       hit_max;
  logic                       pending_q;
  logic                       gpio_q;
  logic [ext_pkg::DATA_W-1:0] rd_val;
  logic                       wr_en;

  assign rise      = sync2_q && !prev_q;
  assign count_inc = count_q + 1'b1;
  // zero max disables the wrap
  assign hit_max   = (cnt_max_q != '0) && (count_inc >= cnt_max_q);
  assign wr_en     = req_i && write_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync1_q   <= 1'b0;
      sync2_q   <= 1'b0;
      prev_q    <= 1'b0;
      cnt_max_q <= CNT_MAX_RESET;
      count_q   <= '0;
      pending_q <= 1'b0;
      gpio_q    <= 1'b0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr_en && ofs_i == ext_pkg::GPIO_REG_CNT_MAX) begin
        cnt_max_q <= wdata_i;
      end
      if (wr_en && ofs_i == ext_pkg::GPIO_REG_STATUS && wdata_i[0]) begin
        pending_q <= 1'b0;
      end
      // a new hit wins over a clear in the same cycle
      if (rise) begin
        if (hit_max) begin
          count_q   <= '0;
          gpio_q    <= !gpio_q;
          pending_q <= 1'b1;
        end else begin
          count_q <= count_inc;
        end
      end
    end
  end

  always_comb begin
    case (ofs_i)
      ext_pkg::GPIO_REG_CNT_MAX: rd_val = cnt_max_q;
      ext_pkg::GPIO_REG_COUNT:   rd_val = count_q;
      ext_pkg::GPIO_REG_STATUS:  rd_val = {{(ext_pkg::DATA_W - 1){1'b0}}, pending_q};
      default:                   rd_val = '0;
    endcase
  end

  // read data held until the next read strobe
  always_ff @(posedge clk_i) begin
    if (req_i && !write_i) begin
      rdata_o <= rd_val;
    end
  end

  assign gpio_o = gpio_q;
  assign intr_o = pending_q;

endmodule

// ==== logic/mem_req_fifo.sv ====
// request FIFO in front of the slow memory
// grants while not full, offers the head entry to the memory
`timescale 1ns/1ps

module mem_req_fifo #(
  parameter int unsigned DEPTH = ext_pkg::FIFO_DEPTH
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       mem_req_i,
  input  logic                       mem_we_i,
  input  logic [3:0]                 mem_be_i,
  input  logic [ext_pkg::ADDR_W-1:0] mem_addr_i,
  input  logic [ext_pkg::DATA_W-1:0] mem_wdata_i,
  input  logic                       pop_i,
  output logic                       mem_gnt_o,
  output logic                       fifo_valid_o,
  output logic                       fifo_we_o,
  output logic [3:0]                 fifo_be_o,
  output logic [ext_pkg::ADDR_W-1:0] fifo_addr_o,
  output logic [ext_pkg::DATA_W-1:0] fifo_wdata_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic                       we_mem    [DEPTH];
  logic [3:0]                 be_mem    [DEPTH];
  logic [ext_pkg::ADDR_W-1:0] addr_mem  [DEPTH];
  logic [ext_pkg::DATA_W-1:0] wdata_mem [DEPTH];
  logic [PTR_W-1:0]           wr_ptr_q;
  logic [PTR_W-1:0]           rd_ptr_q;
  logic [CNT_W-1:0]           count_q;
  logic                       push;

  assign mem_gnt_o    = (count_q != CNT_W'(DEPTH));
  assign push         = mem_req_i && mem_gnt_o;
  assign fifo_valid_o = (count_q != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      we_mem[wr_ptr_q]    <= mem_we_i;
      be_mem[wr_ptr_q]    <= mem_be_i;
      addr_mem[wr_ptr_q]  <= mem_addr_i;
      wdata_mem[wr_ptr_q] <= mem_wdata_i;
    end
  end

  assign fifo_we_o    = we_mem[rd_ptr_q];
  assign fifo_be_o    = be_mem[rd_ptr_q];
  assign fifo_addr_o  = addr_mem[rd_ptr_q];
  assign fifo_wdata_o = wdata_mem[rd_ptr_q];

  // the memory side only pops what is there
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> count_q != '0);

  // a request refused while full stays on the port until granted
  a_req_held: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_i && !mem_gnt_o |=> mem_req_i && $stable(mem_addr_i));

endmodule

// ==== logic/power_switch_ctrl.sv ====
// power-domain switch register, modelled switch-cell ack delay
// and isolation release after power is acknowledged
`timescale 1ns/1ps

module power_switch_ctrl #(
  parameter int unsigned NUM_DOMAINS        = ext_pkg::NUM_DOMAINS,
  parameter int unsigned SWITCH_ACK_LATENCY = ext_pkg::SWITCH_ACK_LATENCY
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       req_i,
  input  logic                       write_i,
  input  logic [1:0]                 ofs_i,
  input  logic [ext_pkg::DATA_W-1:0] wdata_i,
  output logic [ext_pkg::DATA_W-1:0] rdata_o,
  output logic [NUM_DOMAINS-1:0]     switch_n_o,
  output logic [NUM_DOMAINS-1:0]     iso_n_o
);

  logic [NUM_DOMAINS-1:0]     switch_off_q;
  // switch cells, one stage per cycle of ack latency
  logic [NUM_DOMAINS-1:0]     ack_sr_q [SWITCH_ACK_LATENCY];
  logic [NUM_DOMAINS-1:0]     ack_n;
  logic [ext_pkg::DATA_W-1:0] rd_val;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      switch_off_q <= '0;
      for (int i = 0; i < SWITCH_ACK_LATENCY; i++) begin
        ack_sr_q[i] <= '0;
      end
    end else begin
      if (req_i && write_i && ofs_i == ext_pkg::PSW_REG_SWITCH_OFF) begin
        switch_off_q <= wdata_i[NUM_DOMAINS-1:0];
      end
      ack_sr_q[0] <= switch_n_o;
      for (int i = 1; i < SWITCH_ACK_LATENCY; i++) begin
        ack_sr_q[i] <= ack_sr_q[i-1];
      end
    end
  end

  assign switch_n_o = switch_off_q;
  assign ack_n      = ack_sr_q[SWITCH_ACK_LATENCY-1];
  // drop isolation only once the domain is on and acknowledged
  assign iso_n_o    = ~switch_off_q & ~ack_n;

  always_comb begin
    rd_val = '0;
    if (ofs_i == ext_pkg::PSW_REG_SWITCH_OFF) begin
      rd_val[NUM_DOMAINS-1:0] = switch_off_q;
    end else if (ofs_i == ext_pkg::PSW_REG_ACK) begin
      rd_val[NUM_DOMAINS-1:0] = ~ack_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !write_i) begin
      rdata_o <= rd_val;
    end
  end

  // isolation released only if the switch was on a full ack latency earlier
  a_iso_after_ack: assert property (@(posedge clk_i) disable iff (reset_i)
    (iso_n_o & ~$past(iso_n_o) & $past(switch_n_o, SWITCH_ACK_LATENCY)) == '0);

endmodule

// ==== logic/reg_periph_demux.sv ====
// register bus demultiplexer
// strobes one peripheral per request and returns its response a cycle later
`timescale 1ns/1ps

module reg_periph_demux (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       reg_valid_i,
  input  logic                       reg_write_i,
  input  logic [ext_pkg::ADDR_W-1:0] reg_addr_i,
  input  logic [ext_pkg::DATA_W-1:0] reg_wdata_i,
  input  logic [ext_pkg::DATA_W-1:0] gpio_rdata_i,
  input  logic [ext_pkg::DATA_W-1:0] psw_rdata_i,
  output logic                       reg_ready_o,
  output logic [ext_pkg::DATA_W-1:0] reg_rdata_o,
  output logic                       reg_error_o,
  output logic                       gpio_req_o,
  output logic                       psw_req_o,
  output logic                       periph_write_o,
  output logic [1:0]                 periph_ofs_o,
  output logic [ext_pkg::DATA_W-1:0] periph_wdata_o
);

  logic [3:0] periph_idx;
  logic       gpio_hit;
  logic       psw_hit;
  logic       new_req;
  logic       pending_q;
  logic       gpio_sel_q;
  logic       psw_sel_q;

  assign periph_idx = reg_addr_i[ext_pkg::PERIPH_SEL_LSB +: 4];
  assign gpio_hit   = (periph_idx == ext_pkg::GPIO_CNT_IDX);
  assign psw_hit    = (periph_idx == ext_pkg::POWER_SW_IDX);

  // a held request is not taken again while its response is due
  assign new_req = reg_valid_i && !pending_q;

  // strobes go out in the cycle the request is first seen
  assign gpio_req_o     = new_req && gpio_hit;
  assign psw_req_o      = new_req && psw_hit;
  assign periph_write_o = reg_write_i;
  assign periph_ofs_o   = reg_addr_i[ext_pkg::REG_OFS_LSB +: 2];
  assign periph_wdata_o = reg_wdata_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q  <= 1'b0;
      gpio_sel_q <= 1'b0;
      psw_sel_q  <= 1'b0;
    end else begin
      pending_q <= new_req;
      if (new_req) begin
        gpio_sel_q <= gpio_hit;
        psw_sel_q  <= psw_hit;
      end
    end
  end

  // response of the recorded target, zero data for unmapped
  always_comb begin
    if (gpio_sel_q) begin
      reg_rdata_o = gpio_rdata_i;
    end else if (psw_sel_q) begin
      reg_rdata_o = psw_rdata_i;
    end else begin
      reg_rdata_o = '0;
    end
  end

  assign reg_ready_o = pending_q;
  assign reg_error_o = pending_q && !gpio_sel_q && !psw_sel_q;

  // the master holds its request until it sees ready
  a_valid_held: assert property (@(posedge clk_i) disable iff (reset_i)
    reg_valid_i && !reg_ready_o |=> reg_valid_i && $stable(reg_addr_i));

endmodule

// ==== logic/slow_mem.sv ====
// word memory with byte enables behind the request FIFO
// answers each popped request after a fixed latency
`timescale 1ns/1ps

module slow_mem #(
  parameter int unsigned NUM_WORDS = ext_pkg::MEM_WORDS,
  // two cycles or more
  parameter int unsigned LATENCY   = ext_pkg::MEM_LATENCY
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       fifo_valid_i,
  input  logic                       fifo_we_i,
  input  logic [3:0]                 fifo_be_i,
  input  logic [ext_pkg::ADDR_W-1:0] fifo_addr_i,
  input  logic [ext_pkg::DATA_W-1:0] fifo_wdata_i,
  output logic                       pop_o,
  output logic                       mem_rvalid_o,
  output logic [ext_pkg::DATA_W-1:0] mem_rdata_o
);

  localparam int unsigned IDX_W = $clog2(NUM_WORDS);
  localparam int unsigned CNT_W = $clog2(LATENCY);

  logic [ext_pkg::DATA_W-1:0] mem_q [NUM_WORDS];
  logic                       busy_q;
  logic [CNT_W-1:0]           cnt_q;
  logic                       we_q;
  logic [3:0]                 be_q;
  logic [IDX_W-1:0]           idx_q;
  logic [ext_pkg::DATA_W-1:0] wdata_q;
  logic                       done;

  // the access happens in the last busy cycle, rvalid on the next
  assign done  = busy_q && (cnt_q == '0);
  assign pop_o = fifo_valid_i && !busy_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q       <= 1'b0;
      cnt_q        <= '0;
      mem_rvalid_o <= 1'b0;
    end else begin
      mem_rvalid_o <= done;
      if (pop_o) begin
        busy_q <= 1'b1;
        cnt_q  <= CNT_W'(LATENCY - 2);
      end else if (done) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      we_q    <= fifo_we_i;
      be_q    <= fifo_be_i;
      idx_q   <= fifo_addr_i[IDX_W+1:2];
      wdata_q <= fifo_wdata_i;
    end
    if (done) begin
      if (we_q) begin
        for (int b = 0; b < 4; b++) begin
          if (be_q[b]) begin
            mem_q[idx_q][b*8 +: 8] <= wdata_q[b*8 +: 8];
          end
        end
        mem_rdata_o <= '0;
      end else begin
        mem_rdata_o <= mem_q[idx_q];
      end
    end
  end

endmodule

// ==== sources.f ====
logic/ext_pkg.sv
logic/reg_periph_demux.sv
logic/gpio_cnt.sv
logic/power_switch_ctrl.sv
logic/mem_req_fifo.sv
logic/slow_mem.sv
logic/ext_harness_top.sv
test/tb_clk_gen.sv
test/tb_ext_harness.sv

// ==== test/tb_clk_gen.sv ====
// testbench clock and synchronous reset generator
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic reset_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // reset held for the first 8 rising edges
  initial begin
    reset_o = 1'b1;
    repeat (8) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== test/tb_ext_harness.sv ====
// testbench for the external device harness
// register bus, gpio counter, memory path and power sequencing checks
`timescale 1ns/1ps

module tb_ext_harness;

  localparam logic [31:0] CNT_MAX_INIT = 32'd2048;
  localparam int unsigned WAIT_LIMIT   = 200;
  localparam int unsigned N_MEM        = 8;
  localparam int unsigned IDX_HI       = $clog2(ext_pkg::MEM_WORDS) + 1;

  logic        clk;
  logic        reset;
  logic        reg_valid;
  logic        reg_write;
  logic [31:0] reg_addr;
  logic [31:0] reg_wdata;
  logic        reg_ready;
  logic [31:0] reg_rdata;
  logic        reg_error;
  logic        mem_req;
  logic        mem_we;
  logic [3:0]  mem_be;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        mem_gnt;
  logic        mem_rvalid;
  logic [31:0] mem_rdata;
  logic        gpio_in;
  logic        gpio_out;
  logic        intr;
  logic [1:0]  switch_n;
  logic [1:0]  iso_n;

  int          errors;
  // memory reference model, expected responses kept in request order
  logic [31:0] mem_model [int];
  logic [31:0] exp_q [$];
  logic [31:0] exp_data;
  int          granted;
  int          responses;
  bit          gnt_dropped;
  logic        req_we    [3*N_MEM];
  logic [3:0]  req_be    [3*N_MEM];
  logic [31:0] req_addr  [3*N_MEM];
  logic [31:0] req_wdata [3*N_MEM];
  // domain that has to stay powered during the power test
  bit          psw_watch;
  int          other_dom;

  tb_clk_gen i_clk_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  ext_harness_top #(
    .CNT_MAX_RESET (CNT_MAX_INIT)
  ) i_ext_harness_top (
    .clk_i        (clk),
    .reset_i      (reset),
    .reg_valid_i  (reg_valid),
    .reg_write_i  (reg_write),
    .reg_addr_i   (reg_addr),
    .reg_wdata_i  (reg_wdata),
    .reg_ready_o  (reg_ready),
    .reg_rdata_o  (reg_rdata),
    .reg_error_o  (reg_error),
    .mem_req_i    (mem_req),
    .mem_we_i     (mem_we),
    .mem_be_i     (mem_be),
    .mem_addr_i   (mem_addr),
    .mem_wdata_i  (mem_wdata),
    .mem_gnt_o    (mem_gnt),
    .mem_rvalid_o (mem_rvalid),
    .mem_rdata_o  (mem_rdata),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .intr_o       (intr),
    .switch_n_o   (switch_n),
    .iso_n_o      (iso_n)
  );

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    errors++;
    $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("%s", what);
  endtask

  task automatic expect_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else report_value(name, got, exp);
  endtask

  // peripheral window at bit 12, word offset at bit 2
  function automatic logic [31:0] make_addr(input logic [3:0] idx, input logic [1:0] ofs);
    return {16'h0, idx, 8'h0, ofs, 2'b00};
  endfunction

  task automatic bus_access(input logic wr, input logic [3:0] idx, input logic [1:0] ofs,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int unsigned waited;
    waited = 0;
    @(posedge clk);
    reg_valid <= 1'b1;
    reg_write <= wr;
    reg_addr  <= make_addr(idx, ofs);
    reg_wdata <= wdata;
    @(negedge clk);
    while (!reg_ready && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (!reg_ready) begin
      report_problem("register bus never returned ready");
    end
    rdata = reg_rdata;
    err   = reg_error;
    @(posedge clk);
    reg_valid <= 1'b0;
    @(negedge clk);
  endtask

  task automatic write_reg(input logic [3:0] idx, input logic [1:0] ofs,
                           input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b1, idx, ofs, data, rdata, err);
    expect_value("reg_error_o", 32'(err), 32'h0);
  endtask

  task automatic check_reg(input string name, input logic [3:0] idx, input logic [1:0] ofs,
                           input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    bus_access(1'b0, idx, ofs, 32'h0, rdata, err);
    expect_value("reg_error_o", 32'(err), 32'h0);
    expect_value(name, rdata, exp);
  endtask

  task automatic gpio_edge();
    @(posedge clk);
    gpio_in <= 1'b1;
    repeat (4) @(posedge clk);
    gpio_in <= 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // full words first so every byte is known, then partial writes, then reads
  task automatic build_requests();
    int unsigned word_idx [N_MEM];
    for (int i = 0; i < N_MEM; i++) begin
      word_idx[i] = $urandom % ext_pkg::MEM_WORDS;
    end
    for (int i = 0; i < 3*N_MEM; i++) begin
      req_addr[i]  = 32'(word_idx[(i * 5) % N_MEM]) << 2;
      req_we[i]    = (i < 2*N_MEM);
      req_be[i]    = (i < N_MEM) ? 4'hf : 4'($urandom);
      req_wdata[i] = $urandom;
    end
  endtask

  task automatic accept_request(input int k);
    int          idx;
    logic [31:0] old;
    granted++;
    idx = int'(req_addr[k][IDX_HI:2]);
    old = mem_model.exists(idx) ? mem_model[idx] : 32'h0;
    if (req_we[k]) begin
      mem_model[idx] = merge_bytes(old, req_wdata[k], req_be[k]);
      exp_q.push_back(32'h0);
    end else begin
      exp_q.push_back(old);
    end
  endtask

  // back to back requests, each held until granted
  task automatic mem_stream(input int n);
    int          k;
    int unsigned waited;
    k = 0;
    @(posedge clk);
    while (k < n) begin
      mem_req   <= 1'b1;
      mem_we    <= req_we[k];
      mem_be    <= req_be[k];
      mem_addr  <= req_addr[k];
      mem_wdata <= req_wdata[k];
      waited = 0;
      @(negedge clk);
      while (!mem_gnt && waited < WAIT_LIMIT) begin
        gnt_dropped = 1'b1;
        waited++;
        @(negedge clk);
      end
      if (!mem_gnt) begin
        report_problem("memory request was never granted");
        k = n;
      end else begin
        accept_request(k);
        k++;
      end
      @(posedge clk);
    end
    mem_req <= 1'b0;
  endtask

  always @(negedge clk) begin
    if (!reset && mem_rvalid) begin
      responses++;
      if (exp_q.size() == 0) begin
        report_problem("mem_rvalid_o pulsed with no request outstanding");
      end else begin
        exp_data = exp_q.pop_front();
        expect_value("mem_rdata_o", mem_rdata, exp_data);
      end
    end
  end

  always @(negedge clk) begin
    if (psw_watch) begin
      expect_value("switch_n_o (other domain)", 32'(switch_n[other_dom]), 32'h0);
      expect_value("iso_n_o (other domain)", 32'(iso_n[other_dom]), 32'h1);
    end
  end

  a_ready_after_valid: assert property (@(posedge clk) disable iff (reset)
    $rose(reg_valid) |-> !reg_ready ##1 reg_ready ##1 !reg_ready)
    else report_problem("reg_ready_o was not a single pulse one cycle after a new request");

  a_error_zero_data: assert property (@(posedge clk) disable iff (reset)
    reg_error |-> reg_rdata == 32'h0)
    else report_value("reg_rdata_o", reg_rdata, 32'h0);

  a_intr_toggles_gpio: assert property (@(posedge clk) disable iff (reset)
    $rose(intr) |-> gpio_out != $past(gpio_out))
    else report_problem("intr_o rose without a toggle of gpio_o");

  // a SWITCH_OFF write shows on switches and isolation in its response cycle
  a_switch_at_once: assert property (@(posedge clk) disable iff (reset)
    reg_ready && reg_write && reg_addr[15:12] == ext_pkg::POWER_SW_IDX
      && reg_addr[3:2] == ext_pkg::PSW_REG_SWITCH_OFF
      |-> switch_n == reg_wdata[1:0] && (iso_n & reg_wdata[1:0]) == 2'b00)
    else report_value("switch_n_o", 32'(switch_n), 32'(reg_wdata[1:0]));

  initial begin
    logic [31:0] rdata;
    logic        err;
    logic [31:0] cnt_max;
    logic [3:0]  bad_idx;
    logic        gpio_before;
    int unsigned n_edges;
    int unsigned waited;
    int          dom;
    bit          powered;
    logic        iso_prev;

    void'($urandom(17431));
    reg_valid   = 1'b0;
    reg_write   = 1'b0;
    reg_addr    = 32'h0;
    reg_wdata   = 32'h0;
    mem_req     = 1'b0;
    mem_we      = 1'b0;
    mem_be      = 4'h0;
    mem_addr    = 32'h0;
    mem_wdata   = 32'h0;
    gpio_in     = 1'b0;
    errors      = 0;
    granted     = 0;
    responses   = 0;
    gnt_dropped = 1'b0;
    psw_watch   = 1'b0;
    other_dom   = 0;

    waited = 0;
    @(negedge clk);
    while (reset && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (reset) begin
      report_problem("reset was never released");
    end
    expect_value("reg_ready_o", 32'(reg_ready), 32'h0);
    expect_value("reg_error_o", 32'(reg_error), 32'h0);
    expect_value("mem_rvalid_o", 32'(mem_rvalid), 32'h0);
    expect_value("mem_gnt_o", 32'(mem_gnt), 32'h1);
    expect_value("intr_o", 32'(intr), 32'h0);
    expect_value("gpio_o", 32'(gpio_out), 32'h0);
    expect_value("switch_n_o", 32'(switch_n), 32'h0);
    expect_value("iso_n_o", 32'(iso_n), 32'h3);

    // register access and reset value
    check_reg("reg_rdata_o", ext_pkg::GPIO_CNT_IDX, ext_pkg::GPIO_REG_CNT_MAX, CNT_MAX_INIT);
    cnt_max = $urandom;
    write_reg(ext_pkg::GPIO_CNT_IDX, ext_pkg::GPIO_REG_CNT_MAX, cnt_max);
    check_reg("reg_rdata_o", ext_pkg::GPIO_CNT_IDX, ext_pkg::GPIO_REG_CNT_MAX, cnt_max);

    // unmapped window
    bad_idx = 4'(2 + $urandom % 14);
    bus_access(1'b0, bad_idx, 2'($urandom), 32'h0, rdata, err);
    expect_value("reg_error_o", 32'(err), 32'h1);
    expect_value("reg_rdata_o", rdata, 32'h0);
    bus_access(1'b1, bad_idx, 2'd0, $urandom | 32'h3, rdata, err);
    expect_value("reg_error_o", 32'(err), 32'h1);
    check_reg("reg_rdata_o", ext_pkg::GPIO_CNT_IDX, ext_pkg::GPIO_REG_CNT_MAX, cnt_max);
    check_reg("reg_rdata_o", ext_pkg::POWER_SW_IDX, ext_pkg::PSW_REG_SWITCH_OFF, 32'h0);
    expect_value("switch_n_o", 32'(switch_n), 32'h0);

    // gpio edge counting
    n_edges = 3 + $urandom % 8;
    write_reg(ext_pkg::GPIO_CNT_IDX, ext_pkg::GPIO_REG_CNT_MAX, 32'(n_edges));
    gpio_before = gpio_out;
    repeat (n_edges - 1) gpio_edge();
    expect_value("intr_o", 32'(intr), 32'h0);
    expect_value("gpio_o", 32'(gpio_out), 32'(gpio_before));
    check_reg("reg_rdata_o", ext_pkg::GPIO_CNT_IDX, ext_pkg::GPIO_REG_COUNT, n_edges - 1);
    gpio_edge();
    waited = 0;
    while (!intr && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (!intr) begin
      report_problem("gpio interrupt was never raised");
    end
    expect_value("gpio_o", 32'(gpio_out), 32'(!gpio_before));
    check_reg("reg_rdata_o", ext_pkg::GPIO_CNT_IDX, ext_pkg::GPIO_REG_COUNT, 32'h0);
    write_reg(ext_pkg::GPIO_CNT_IDX, ext_pkg::GPIO_REG_STATUS, 32'h1);
    expect_value("intr_o", 32'(intr), 32'h0);

    // memory path
    build_requests();
    mem_stream(3*N_MEM);
    waited = 0;
    while (responses < granted && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    // quiet time so a stray pulse would be counted
    repeat (2*ext_pkg::MEM_LATENCY) @(negedge clk);
    expect_value("mem_rvalid_o pulses", 32'(responses), 32'(granted));
    expect_value("mem_gnt_o grants", 32'(granted), 32'(3*N_MEM));
    assert (gnt_dropped) else report_problem("mem_gnt_o never dropped while the FIFO filled");

    // power sequencing on one domain
    dom       = int'($urandom % 2);
    other_dom = 1 - dom;
    psw_watch = 1'b1;
    write_reg(ext_pkg::POWER_SW_IDX, ext_pkg::PSW_REG_SWITCH_OFF, 32'(1 << dom));
    expect_value("switch_n_o", 32'(switch_n[dom]), 32'h1);
    expect_value("iso_n_o", 32'(iso_n[dom]), 32'h0);
    waited = 0;
    powered = 1'b1;
    while (powered && waited < WAIT_LIMIT) begin
      bus_access(1'b0, ext_pkg::POWER_SW_IDX, ext_pkg::PSW_REG_ACK, 32'h0, rdata, err);
      powered = rdata[dom];
      waited++;
    end
    if (powered) begin
      report_problem("switched domain never reported unpowered");
    end
    write_reg(ext_pkg::POWER_SW_IDX, ext_pkg::PSW_REG_SWITCH_OFF, 32'h0);
    expect_value("switch_n_o", 32'(switch_n[dom]), 32'h0);
    waited = 0;
    powered = 1'b0;
    while (!powered && waited < WAIT_LIMIT) begin
      iso_prev = iso_n[dom];
      bus_access(1'b0, ext_pkg::POWER_SW_IDX, ext_pkg::PSW_REG_ACK, 32'h0, rdata, err);
      powered = rdata[dom];
      // still unpowered, so isolation must have held
      if (!powered) begin
        expect_value("iso_n_o", 32'(iso_prev), 32'h0);
      end
      waited++;
    end
    if (!powered) begin
      report_problem("domain never reported power after switching on");
    end
    expect_value("iso_n_o", 32'(iso_n[dom]), 32'h1);
    psw_watch = 1'b0;

    $display("checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
